// ==== mvdm_mini.f ====
+incdir+tests
rtl/mvdm_pkg.sv
rtl/frame_loader.sv
rtl/frame_store.sv
rtl/block_interp.sv
rtl/sad_search.sv
rtl/result_shifter.sv
rtl/mvdm_top.sv
tests/mvdm_tb.sv

// ==== rtl/block_interp.sv ====
`default_nettype none

module block_interp #(
    parameter int img_w = mvdm_pkg::IMG_W_DEF
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       job_start,
    input  wire mvdm_pkg::mv_word_t         mv_x,
    input  wire mvdm_pkg::mv_word_t         mv_y,
    output logic [$clog2(img_w*img_w)-1:0]  rd_addr,
    input  wire mvdm_pkg::pixel_t           rd_data,
    output mvdm_pkg::interp_blk_t           blk,
    output logic                            interp_done
);
    import mvdm_pkg::*;

    localparam int ADDR_W = $clog2(img_w * img_w);
    localparam int CW     = $clog2(FETCH);

    logic [7:0]  base_x;
    logic [7:0]  base_y;
    logic [3:0]  frac_x;
    logic [3:0]  frac_y;
    logic        fetching;
    logic [CW-1:0] fr;
    logic [CW-1:0] fc;
    logic        cap_en;
    logic [CW-1:0] cap_r;
    logic [CW-1:0] cap_c;
    logic        filt_go;

    pixel_t      pix [FETCH][FETCH];
    hsamp_t      hs  [FETCH][WIN];
    interp_blk_t blk_next;

    // (16 - f) * a + f * b, same as 16a + f(b - a)
    function automatic hsamp_t hfilt(pixel_t a, pixel_t b, logic [3:0] f);
        return (hsamp_t'(16) - hsamp_t'(f)) * hsamp_t'(a) + hsamp_t'(f) * hsamp_t'(b);
    endfunction

    function automatic vsamp_t vfilt(hsamp_t a, hsamp_t b, logic [3:0] f);
        return (vsamp_t'(16) - vsamp_t'(f)) * vsamp_t'(a) + vsamp_t'(f) * vsamp_t'(b);
    endfunction

    assign rd_addr = ADDR_W'((int'(base_y) + int'(fr)) * img_w + int'(base_x) + int'(fc));

    // ======================================================================
    // window walk, capture runs one cycle behind
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetching    <= 1'b0;
            fr          <= '0;
            fc          <= '0;
            cap_en      <= 1'b0;
            cap_r       <= '0;
            cap_c       <= '0;
            filt_go     <= 1'b0;
            interp_done <= 1'b0;
        end else begin
            if (job_start) begin
                fetching <= 1'b1;
                fr       <= '0;
                fc       <= '0;
            end else if (fetching) begin
                if (fc == CW'(FETCH - 1)) begin
                    fc <= '0;
                    if (fr == CW'(FETCH - 1))
                        fetching <= 1'b0;
                    else
                        fr <= fr + 1'b1;
                end else begin
                    fc <= fc + 1'b1;
                end
            end
            cap_en      <= fetching;
            cap_r       <= fr;
            cap_c       <= fc;
            filt_go     <= cap_en && (cap_r == CW'(FETCH - 1)) && (cap_c == CW'(FETCH - 1));
            interp_done <= filt_go;             // same edge that loads blk
        end
    end

    always_ff @(posedge clk) begin
        if (job_start) begin
            base_x <= mv_x.mv.pos;
            base_y <= mv_y.mv.pos;
            frac_x <= mv_x.mv.frac;
            frac_y <= mv_y.mv.frac;
        end
        if (cap_en)
            pix[cap_r][cap_c] <= rd_data;
        if (filt_go)
            blk <= blk_next;
    end

    // ======================================================================
    // bilinear, across then down
    // ======================================================================
    always_comb begin
        for (int r = 0; r < FETCH; r++)
            for (int c = 0; c < WIN; c++)
                hs[r][c] = hfilt(pix[r][c], pix[r][c+1], frac_x);
        for (int r = 0; r < WIN; r++)
            for (int c = 0; c < WIN; c++)
                blk_next[r][c] = vfilt(hs[r][c], hs[r+1][c], frac_y);
    end

endmodule

`default_nettype wire

// ==== rtl/frame_loader.sv ====
`default_nettype none

module frame_loader #(
    parameter int img_w = mvdm_pkg::IMG_W_DEF
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          in_valid,
    input  wire logic                          in_valid2,
    input  wire mvdm_pkg::mv_word_t            in_data,
    output logic                               wr_en_l0,
    output logic                               wr_en_l1,
    output logic [$clog2(img_w*img_w)-1:0]     wr_addr,
    output mvdm_pkg::pixel_t                   wr_data,
    output mvdm_pkg::mv_word_t                 mv_x_l0,
    output mvdm_pkg::mv_word_t                 mv_y_l0,
    output mvdm_pkg::mv_word_t                 mv_x_l1,
    output mvdm_pkg::mv_word_t                 mv_y_l1,
    output logic                               job_start
);
    import mvdm_pkg::*;

    localparam int ADDR_W = $clog2(img_w * img_w);
    localparam int LAST   = img_w * img_w - 1;

    logic [ADDR_W-1:0] pix_cnt;
    logic              list_sel;    // 0 while filling list 0
    logic [1:0]        mv_cnt;
    logic              last_mv;

    assign last_mv = in_valid2 && (mv_cnt == 2'd3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt   <= '0;
            list_sel  <= 1'b0;
            mv_cnt    <= '0;
            wr_en_l0  <= 1'b0;
            wr_en_l1  <= 1'b0;
            job_start <= 1'b0;
        end else begin
            wr_en_l0  <= in_valid && !list_sel;
            wr_en_l1  <= in_valid && list_sel;
            job_start <= last_mv;
            if (in_valid) begin
                if (pix_cnt == ADDR_W'(LAST)) begin
                    pix_cnt  <= '0;
                    list_sel <= ~list_sel;      // frame full, next list
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end
            if (in_valid2)
                mv_cnt <= mv_cnt + 1'b1;        // wraps after list 1 y
            if (last_mv) begin
                pix_cnt  <= '0;                 // ready for next job
                list_sel <= 1'b0;
            end
        end
    end

    // write port and vectors
    always_ff @(posedge clk) begin
        if (in_valid) begin
            wr_addr <= pix_cnt;
            wr_data <= in_data.pix.pel;
        end
        if (in_valid2) begin
            case (mv_cnt)
                2'd0:    mv_x_l0.mv <= in_data.mv;
                2'd1:    mv_y_l0.mv <= in_data.mv;
                2'd2:    mv_x_l1.mv <= in_data.mv;
                default: mv_y_l1.mv <= in_data.mv;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/frame_store.sv ====
`default_nettype none

module frame_store #(
    parameter int img_w = mvdm_pkg::IMG_W_DEF
) (
    input  wire logic                           clk,
    input  wire logic                           wr_en,
    input  wire logic [$clog2(img_w*img_w)-1:0] wr_addr,
    input  wire mvdm_pkg::pixel_t               wr_data,
    input  wire logic [$clog2(img_w*img_w)-1:0] rd_addr,
    output mvdm_pkg::pixel_t                    rd_data
);
    import mvdm_pkg::*;

    pixel_t mem [img_w*img_w];      // one frame, raster order

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];    // data one cycle after address
    end

endmodule

`default_nettype wire

// ==== rtl/mvdm_pkg.sv ====
`default_nettype none

package mvdm_pkg;

    // ======================================================================
    // geometry
    // ======================================================================
    localparam int IMG_W_DEF = 32;          // frame edge in pixels
    localparam int BLK       = 4;           // compared block edge
    localparam int SRCH      = 9;           // 3x3 mirrored search points
    localparam int WIN       = BLK + 2;     // interpolated window edge
    localparam int FETCH     = WIN + 1;     // integer pixels needed per edge
    localparam int RESULT_W  = 28;          // index + sad, serialized

    typedef logic [7:0]  pixel_t;
    typedef logic [11:0] hsamp_t;           // sixteenths after horizontal pass
    typedef logic [15:0] vsamp_t;           // 256ths after vertical pass
    typedef logic [23:0] sad_t;
    typedef logic [3:0]  point_t;

    // same input bus carries pixels and motion vectors
    typedef struct packed {
        pixel_t     pel;
        logic [3:0] unused;
    } pix_view_t;

    typedef struct packed {
        logic [7:0] pos;                    // integer position
        logic [3:0] frac;                   // sixteenth-pel
    } mv_view_t;

    typedef union packed {
        pix_view_t pix;
        mv_view_t  mv;
    } mv_word_t;

    typedef vsamp_t [WIN-1:0][WIN-1:0] interp_blk_t;   // [row][col]

endpackage

`default_nettype wire

// ==== rtl/mvdm_top.sv ====
`default_nettype none

module mvdm_top #(
    parameter int img_w = mvdm_pkg::IMG_W_DEF
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                in_valid,
    input  wire logic                in_valid2,
    input  wire mvdm_pkg::mv_word_t  in_data,
    output logic                     out_valid,
    output logic                     out_sad
);
    import mvdm_pkg::*;

    localparam int ADDR_W = $clog2(img_w * img_w);

    // loader to stores
    logic              wr_en_l0;
    logic              wr_en_l1;
    logic [ADDR_W-1:0] wr_addr;
    pixel_t            wr_data;

    // loader to filters
    mv_word_t          mv_x_l0;
    mv_word_t          mv_y_l0;
    mv_word_t          mv_x_l1;
    mv_word_t          mv_y_l1;
    logic              job_start;

    // stores to filters
    logic [ADDR_W-1:0] rd_addr_l0;
    logic [ADDR_W-1:0] rd_addr_l1;
    pixel_t            rd_data_l0;
    pixel_t            rd_data_l1;

    // filters to search, search to output
    interp_blk_t       blk_l0;
    interp_blk_t       blk_l1;
    logic              done_l0;
    logic              done_l1;
    point_t            best_point;
    sad_t              best_sad;
    logic              search_done;

    frame_loader #(.img_w(img_w)) loader_i (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_valid2(in_valid2),
        .in_data(in_data), .wr_en_l0(wr_en_l0), .wr_en_l1(wr_en_l1),
        .wr_addr(wr_addr), .wr_data(wr_data),
        .mv_x_l0(mv_x_l0), .mv_y_l0(mv_y_l0), .mv_x_l1(mv_x_l1), .mv_y_l1(mv_y_l1),
        .job_start(job_start)
    );

    frame_store #(.img_w(img_w)) store_l0_i (
        .clk(clk), .wr_en(wr_en_l0), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr_l0), .rd_data(rd_data_l0)
    );

    frame_store #(.img_w(img_w)) store_l1_i (
        .clk(clk), .wr_en(wr_en_l1), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr_l1), .rd_data(rd_data_l1)
    );

    block_interp #(.img_w(img_w)) interp_l0_i (
        .clk(clk), .rst_n(rst_n), .job_start(job_start), .mv_x(mv_x_l0), .mv_y(mv_y_l0),
        .rd_addr(rd_addr_l0), .rd_data(rd_data_l0), .blk(blk_l0), .interp_done(done_l0)
    );

    block_interp #(.img_w(img_w)) interp_l1_i (
        .clk(clk), .rst_n(rst_n), .job_start(job_start), .mv_x(mv_x_l1), .mv_y(mv_y_l1),
        .rd_addr(rd_addr_l1), .rd_data(rd_data_l1), .blk(blk_l1), .interp_done(done_l1)
    );

    sad_search search_i (
        .clk(clk), .rst_n(rst_n), .blk_l0(blk_l0), .blk_l1(blk_l1),
        .done_l0(done_l0), .done_l1(done_l1), .best_point(best_point),
        .best_sad(best_sad), .search_done(search_done)
    );

    result_shifter shifter_i (
        .clk(clk), .rst_n(rst_n), .search_done(search_done), .best_point(best_point),
        .best_sad(best_sad), .out_valid(out_valid), .out_sad(out_sad)
    );

endmodule

`default_nettype wire

// ==== rtl/result_shifter.sv ====
`default_nettype none

module result_shifter (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               search_done,
    input  wire mvdm_pkg::point_t   best_point,
    input  wire mvdm_pkg::sad_t     best_sad,
    output logic                    out_valid,
    output logic                    out_sad
);
    import mvdm_pkg::*;

    localparam int CNT_W = $clog2(RESULT_W);

    logic [RESULT_W-1:0] word;
    logic [RESULT_W-1:0] sreg;
    logic [CNT_W-1:0]    bits_left;

    assign word = {best_point, best_sad};   // index above sad

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_sad   <= 1'b0;
            bits_left <= '0;
        end else if (search_done) begin
            out_valid <= 1'b1;
            out_sad   <= word[0];               // lsb first
            bits_left <= CNT_W'(RESULT_W - 1);
        end else if (bits_left != '0) begin
            out_sad   <= sreg[0];
            bits_left <= bits_left - 1'b1;
        end else begin
            out_valid <= 1'b0;
            out_sad   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (search_done)
            sreg <= word >> 1;
        else
            sreg <= sreg >> 1;
    end

endmodule

`default_nettype wire

// ==== rtl/sad_search.sv ====
`default_nettype none

module sad_search (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire mvdm_pkg::interp_blk_t  blk_l0,
    input  wire mvdm_pkg::interp_blk_t  blk_l1,
    input  wire logic                   done_l0,
    input  wire logic                   done_l1,
    output mvdm_pkg::point_t            best_point,
    output mvdm_pkg::sad_t              best_sad,
    output logic                        search_done
);
    import mvdm_pkg::*;

    localparam int SPAN   = 3;              // points per search row
    localparam int MIRROR = WIN - BLK;      // list 1 moves the other way
    localparam int RW     = $clog2(BLK);

    logic          seen_l0;
    logic          seen_l1;
    logic          running;
    logic          go;
    logic          pt_end;
    point_t        pt;
    logic [RW-1:0] row;
    sad_t          acc;
    sad_t          row_sum;
    sad_t          pt_sad;
    int            sy;
    int            sx;
    vsamp_t        a;
    vsamp_t        b;

    assign go     = (seen_l0 || done_l0) && (seen_l1 || done_l1) && !running;
    assign pt_end = running && (row == RW'(BLK - 1));
    assign pt_sad = acc + row_sum;

    // one block row of absolute differences
    always_comb begin
        sy      = int'(pt) / SPAN;
        sx      = int'(pt) % SPAN;
        row_sum = '0;
        a       = '0;
        b       = '0;
        for (int j = 0; j < BLK; j++) begin
            a       = blk_l0[sy + int'(row)][sx + j];
            b       = blk_l1[MIRROR - sy + int'(row)][MIRROR - sx + j];
            row_sum = row_sum + sad_t'((a >= b) ? a - b : b - a);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_l0     <= 1'b0;
            seen_l1     <= 1'b0;
            running     <= 1'b0;
            pt          <= '0;
            row         <= '0;
            acc         <= '0;
            search_done <= 1'b0;
        end else begin
            search_done <= 1'b0;
            if (go) begin
                seen_l0 <= 1'b0;
                seen_l1 <= 1'b0;
                running <= 1'b1;
                pt      <= '0;
                row     <= '0;
                acc     <= '0;
            end else begin
                if (done_l0) seen_l0 <= 1'b1;
                if (done_l1) seen_l1 <= 1'b1;
                if (pt_end) begin
                    row <= '0;
                    acc <= '0;
                    if (pt == point_t'(SRCH - 1)) begin
                        running     <= 1'b0;
                        search_done <= 1'b1;
                    end else begin
                        pt <= pt + 1'b1;
                    end
                end else if (running) begin
                    row <= row + 1'b1;
                    acc <= pt_sad;
                end
            end
        end
    end

    // strict less keeps the lowest index on ties
    always_ff @(posedge clk) begin
        if (pt_end && (pt == '0 || pt_sad < best_sad)) begin
            best_sad   <= pt_sad;
            best_point <= pt;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the mvdm_mini simulation with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module mvdm_tb -f mvdm_mini.f -o mvdm_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/mvdm_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1

// ==== tests/mvdm_model.svh ====
`ifndef MVDM_MODEL_SVH
`define MVDM_MODEL_SVH

// integer pixel of one list, frame copy kept by the testbench
function automatic int pel_at(input int list, input int y, input int x);
    return frame_px[list][y * IMG_W + x];
endfunction

// horizontal pass, sixteenths
function automatic int hsample(input int list, input int y, input int x);
    int a;
    int b;
    a = pel_at(list, y, x);
    b = pel_at(list, y, x + 1);
    return 16 * a + mv_fx[list] * (b - a);
endfunction

// vertical pass over horizontal samples, 256ths
function automatic int vsample(input int list, input int r, input int c);
    int y;
    int x;
    int a;
    int b;
    y = mv_py[list] + r;
    x = mv_px[list] + c;
    a = hsample(list, y, x);
    b = hsample(list, y + 1, x);
    return 16 * a + mv_fy[list] * (b - a);
endfunction

// list 0 moves by (sy, sx), list 1 by the opposite offset
function automatic int point_sad(input int k);
    int sy;
    int sx;
    int d;
    int acc;
    sy  = k / 3;
    sx  = k % 3;
    acc = 0;
    for (int i = 0; i < BLK; i++) begin
        for (int j = 0; j < BLK; j++) begin
            d   = vsample(0, sy + i, sx + j) - vsample(1, 2 - sy + i, 2 - sx + j);
            acc = acc + ((d < 0) ? -d : d);
        end
    end
    return acc;
endfunction

task automatic expected_result(output point_t pt, output sad_t sad);
    int best_k;
    int best_s;
    int s;
    best_k = 0;
    best_s = point_sad(0);
    for (int k = 1; k < SRCH; k++) begin
        s = point_sad(k);
        if (s < best_s) begin       // ties keep the lower index
            best_s = s;
            best_k = k;
        end
    end
    pt  = point_t'(best_k);
    sad = sad_t'(best_s);
endtask

`endif

// ==== tests/mvdm_tb.sv ====
`default_nettype none

module mvdm_tb;
    import mvdm_pkg::*;

    localparam int IMG_W     = 32;
    localparam int NPIX      = IMG_W * IMG_W;
    localparam int N_JOBS    = 6;
    localparam int WD_MARGIN = 2000;    // cycles on top of the loading time
    localparam int OUT_WAIT  = 1000;    // cycles allowed from last vector to out_valid

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    logic     in_valid2;
    mv_word_t in_data;
    logic     out_valid;
    logic     out_sad;

    integer   seed;
    int       value_errs;
    int       proto_errs;

    // reference copies of the current job
    int       frame_px [2][NPIX];
    int       mv_px [2];
    int       mv_py [2];
    int       mv_fx [2];
    int       mv_fy [2];

`include "mvdm_model.svh"

    mvdm_top #(.img_w(IMG_W)) dut_i (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_valid2(in_valid2),
        .in_data(in_data), .out_valid(out_valid), .out_sad(out_sad)
    );

    always #4 clk = ~clk;

    // ======================================================================
    // watchdog
    // ======================================================================
    initial begin
        #((N_JOBS * 2 * NPIX + WD_MARGIN) * 8);
        $display("watchdog expired before all jobs finished at %0t", $time);
        $display("TEST FAILED");
        $finish;
    end

    // ======================================================================
    // compare tasks
    // ======================================================================
    task automatic check_point(input string name, input point_t exp, input point_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_sad(input string name, input sad_t exp, input sad_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            value_errs++;
        end
    endtask

    // both frames in raster order, output must stay idle meanwhile
    task automatic load_frames(input bit flat);
        int fill;
        int pel;
        bit busy_seen;
        fill      = $random(seed) & 8'hff;
        busy_seen = 1'b0;
        for (int l = 0; l < 2; l++) begin
            for (int addr = 0; addr < NPIX; addr++) begin
                pel = flat ? fill : ($random(seed) & 8'hff);
                frame_px[l][addr] = pel;
                @(negedge clk);
                if (out_valid || out_sad)
                    busy_seen = 1'b1;
                in_valid = 1'b1;
                in_data  = {8'(pel), 4'($random(seed))};   // low bits are don't care
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_data  = '0;
        if (busy_seen) begin
            $display("output was active while frames were loading, at %0t", $time);
            proto_errs++;
        end
    endtask

    task automatic send_vectors(input bit zero_frac);
        for (int l = 0; l < 2; l++) begin
            mv_px[l] = $unsigned($random(seed)) % (IMG_W - FETCH + 1);
            mv_py[l] = $unsigned($random(seed)) % (IMG_W - FETCH + 1);
            mv_fx[l] = zero_frac ? 0 : ($random(seed) & 15);
            mv_fy[l] = zero_frac ? 0 : ($random(seed) & 15);
        end
        // order: l0 x, l0 y, l1 x, l1 y
        for (int w = 0; w < 4; w++) begin
            @(negedge clk);
            in_valid2 = 1'b1;
            if (w % 2 == 0)
                in_data = {8'(mv_px[w / 2]), 4'(mv_fx[w / 2])};
            else
                in_data = {8'(mv_py[w / 2]), 4'(mv_fy[w / 2])};
        end
        @(negedge clk);
        in_valid2 = 1'b0;
        in_data   = '0;
    endtask

    // serial result, lsb first, sampled mid-cycle
    task automatic collect_result(output point_t pt, output sad_t sad, output bit ok);
        logic [RESULT_W-1:0] word;
        int                  wait_cnt;
        int                  nbits;
        ok       = 1'b0;
        word     = '0;
        wait_cnt = 0;
        nbits    = 0;
        while (!out_valid && wait_cnt < OUT_WAIT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!out_valid) begin
            $display("no out_valid within %0d cycles of the last vector", OUT_WAIT);
            proto_errs++;
        end else begin
            while (out_valid && nbits <= RESULT_W) begin
                if (nbits < RESULT_W)
                    word[nbits] = out_sad;
                nbits++;
                @(negedge clk);
            end
            if (nbits != RESULT_W) begin
                $display("out_valid window was %0d cycles long instead of %0d, at %0t",
                         nbits, RESULT_W, $time);
                proto_errs++;
            end else begin
                ok = 1'b1;
            end
        end
        pt  = point_t'(word >> $bits(sad_t));
        sad = sad_t'(word);
    endtask

    task automatic run_job(input bit flat, input bit zero_frac);
        point_t exp_pt;
        point_t got_pt;
        sad_t   exp_sad;
        sad_t   got_sad;
        bit     ok;
        load_frames(flat);
        send_vectors(zero_frac);
        expected_result(exp_pt, exp_sad);
        collect_result(got_pt, got_sad, ok);
        if (ok) begin
            check_point("best_point", exp_pt, got_pt);
            check_sad("best_sad", exp_sad, got_sad);
            if (flat) begin                 // all points tie at zero
                check_point("best_point", point_t'(0), got_pt);
                check_sad("best_sad", sad_t'(0), got_sad);
            end
        end
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        seed       = 32'h7921da4d;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_valid2  = 1'b0;
        in_data    = '0;
        value_errs = 0;
        proto_errs = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        run_job(1'b0, 1'b1);                // integer vectors only
        run_job(1'b1, 1'b0);                // flat frames
        for (int j = 2; j < N_JOBS; j++)
            run_job(1'b0, 1'b0);            // back to back, fractional

        $display("value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
        if (value_errs + proto_errs == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
